// File: include/l2_xbar_config.svh
/*
  Sizing of the L2 interconnect, shared by the package and all RTL.
  Include wherever a port count, bank count or address field width is needed.
*/
`ifndef L2_XBAR_CONFIG_SVH
`define L2_XBAR_CONFIG_SVH

// initiator side
`define L2_N_MASTERS 4

// bank side, bank count must stay a power of two
`define L2_N_BANKS   8
`define L2_BANK_W    3

// rows per bank are 2**L2_ROW_W words
`define L2_ROW_W     8

// byte address window, offset + bank + row
`define L2_ADDR_W    13

// data path
`define L2_DATA_W    32
`define L2_BE_W      4

`endif

// File: run_sim.sh
#!/bin/sh
# Builds the L2 interconnect testbench with Verilator and runs it.
# The script exits with the status of the simulation binary.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --timescale 1ns/100ps \
  --top-module tb_l2_interconnect \
  -f src.f \
  -o sim_l2_interconnect
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit "$status"
fi

if [ ! -x ./obj_dir/sim_l2_interconnect ]; then
  echo "simulation binary not found"
  exit 1
fi

./obj_dir/sim_l2_interconnect
status=$?
if [ "$status" -ne 0 ]; then
  echo "simulation ended with status $status"
fi
exit "$status"

// File: source/l2_addr_decoder.sv
/*
  Bank decode for one initiator. Splits the byte address into the
  interleaving bank field and the row field, combinationally.
*/
`timescale 1ns/100ps
`include "l2_xbar_config.svh"

module l2_addr_decoder
  import l2_xbar_pkg::*;
(
  input  l2_req_t   req_i,
  output bank_sel_t bank_sel_o,
  output row_t      row_o
);

  // word aligned, so the byte offset is simply skipped
  localparam int unsigned OFFSET_W = $clog2(`L2_BE_W);

  logic [`L2_BANK_W-1:0] bank_idx;

  // low word bits pick the bank, consecutive words hit consecutive banks
  assign bank_idx = req_i.add[OFFSET_W +: `L2_BANK_W];
  assign row_o    = req_i.add[OFFSET_W + `L2_BANK_W +: `L2_ROW_W];

  always_comb begin : decode
    bank_sel_o = '0;
    if (req_i.req) begin
      bank_sel_o[bank_idx] = 1'b1;
    end
  end

  // a single request never fans out to two banks
  always_comb begin : chk_sel
    assert ($onehot0(bank_sel_o))
      else $error("bank select not one-hot: %b", bank_sel_o);
  end

endmodule

// File: source/l2_bank_arbiter.sv
/*
  Round-robin arbiter in front of one bank. Grants one requesting initiator
  per cycle and forms the bank request tagged with the winner's one-hot ID.
*/
`timescale 1ns/100ps
`include "l2_xbar_config.svh"

module l2_bank_arbiter
  import l2_xbar_pkg::*;
(
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  l2_req_t    [`L2_N_MASTERS-1:0]    req_i,
  input  master_id_t                        sel_i,   // decoder column for this bank
  input  row_t       [`L2_N_MASTERS-1:0]    row_i,
  output master_id_t                        gnt_o,
  output l2_bank_req_t                      bank_req_o
);

  localparam int unsigned IDX_W = $clog2(`L2_N_MASTERS);

  arb_state_e       ptr_q;
  logic [IDX_W-1:0] win_idx;
  logic             win_valid;

  // first requester at or after the pointer
  always_comb begin : pick
    logic [IDX_W-1:0] cand;
    win_idx   = ptr_q;
    win_valid = 1'b0;
    for (int unsigned off = 0; off < `L2_N_MASTERS; off++) begin
      cand = IDX_W'((int'(ptr_q) + off) % `L2_N_MASTERS);
      if (!win_valid && sel_i[cand]) begin
        win_valid = 1'b1;
        win_idx   = cand;
      end
    end
  end

  always_comb begin : grant
    gnt_o = '0;
    if (win_valid) begin
      gnt_o[win_idx] = 1'b1;
    end
  end

  // payload mux, harmless when nobody wins since req stays low
  assign bank_req_o.req   = win_valid;
  assign bank_req_o.wen   = req_i[win_idx].wen;
  assign bank_req_o.row   = row_i[win_idx];
  assign bank_req_o.wdata = req_i[win_idx].wdata;
  assign bank_req_o.be    = req_i[win_idx].be;
  assign bank_req_o.id    = gnt_o;

  // winner drops to lowest priority
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ptr_q <= ARB_M0;
    end else if (win_valid) begin
      ptr_q <= arb_state_e'((int'(win_idx) + 1) % `L2_N_MASTERS);
    end
  end

  // exactly one grant under any contention, none when the bank is idle
  a_gnt_onehot : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (|sel_i) ? $onehot(gnt_o) : (gnt_o == '0)
  ) else $error("bank arbiter grant %b for select %b", gnt_o, sel_i);

  // no requester waits more than one full round
  a_no_starve : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (sel_i[0] && !gnt_o[0]) |-> ##[1:`L2_N_MASTERS] (gnt_o[0] || !sel_i[0])
  ) else $error("initiator 0 starved at bank arbiter");

endmodule

// File: source/l2_interconnect.sv
/*
  Top level of the L2 interconnect: the crossbar in front of the array
  of SRAM banks. Initiators see req/gnt and a one-cycle response.
*/
`timescale 1ns/100ps
`include "l2_xbar_config.svh"

module l2_interconnect
  import l2_xbar_pkg::*;
(
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  l2_req_t [`L2_N_MASTERS-1:0]   req_i,
  output master_id_t                    gnt_o,
  output l2_rsp_t [`L2_N_MASTERS-1:0]   rsp_o
);

  // bank side of the crossbar
  l2_bank_req_t [`L2_N_BANKS-1:0] bank_req;
  l2_bank_rsp_t [`L2_N_BANKS-1:0] bank_rsp;

  l2_xbar i_xbar (
    .clk_i      ( clk_i    ),
    .rst_ni     ( rst_ni   ),
    .req_i      ( req_i    ),
    .gnt_o      ( gnt_o    ),
    .rsp_o      ( rsp_o    ),
    .bank_req_o ( bank_req ),
    .bank_rsp_i ( bank_rsp )
  );

  // word-interleaved banks, bank b holds words with index b mod N_BANKS
  for (genvar b = 0; b < `L2_N_BANKS; b++) begin : g_bank
    l2_sram_bank i_bank (
      .clk_i  ( clk_i       ),
      .rst_ni ( rst_ni      ),
      .req_i  ( bank_req[b] ),
      .rsp_o  ( bank_rsp[b] )
    );
  end

endmodule

// File: source/l2_resp_router.sv
/*
  Return path of the crossbar. Each initiator picks up the bank response
  whose one-hot ID carries its bit; purely combinational.
*/
`timescale 1ns/100ps
`include "l2_xbar_config.svh"

module l2_resp_router
  import l2_xbar_pkg::*;
(
  input  l2_bank_rsp_t [`L2_N_BANKS-1:0]   bank_rsp_i,
  output l2_rsp_t      [`L2_N_MASTERS-1:0] rsp_o
);

  // hit[m][b]: bank b answers initiator m this cycle
  bank_sel_t [`L2_N_MASTERS-1:0] hit;

  always_comb begin : match
    for (int m = 0; m < `L2_N_MASTERS; m++) begin
      for (int b = 0; b < `L2_N_BANKS; b++) begin
        hit[m][b] = bank_rsp_i[b].r_valid & bank_rsp_i[b].r_id[m];
      end
    end
  end

  // at most one hit per initiator, so a priority loop is enough
  always_comb begin : steer
    for (int m = 0; m < `L2_N_MASTERS; m++) begin
      rsp_o[m].r_valid = 1'b0;
      rsp_o[m].r_rdata = '0;
      for (int b = 0; b < `L2_N_BANKS; b++) begin
        if (hit[m][b]) begin
          rsp_o[m].r_valid = 1'b1;
          rsp_o[m].r_rdata = bank_rsp_i[b].r_rdata;
        end
      end
    end
  end

  // arbiters grant an initiator at one bank per cycle at most,
  // so two responses for the same initiator mean a broken grant path
  always_comb begin : chk_unique
    for (int m = 0; m < `L2_N_MASTERS; m++) begin
      assert ($onehot0(hit[m]))
        else $error("initiator %0d gets responses from banks %b", m, hit[m]);
    end
  end

endmodule

// File: source/l2_sram_bank.sv
/*
  Single-port SRAM bank model with byte-enabled writes. Every accepted
  request answers one cycle later with read data, response valid and the
  echoed initiator ID. Reads return the word as it was before the access.
*/
`timescale 1ns/100ps
`include "l2_xbar_config.svh"

module l2_sram_bank
  import l2_xbar_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  input  l2_bank_req_t req_i,
  output l2_bank_rsp_t rsp_o
);

  localparam int unsigned N_WORDS = 2 ** `L2_ROW_W;

  data_t      mem [N_WORDS];
  data_t      r_rdata_q;
  master_id_t r_id_q;
  logic       r_valid_q;

  // array and read path
  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      if (!req_i.wen) begin  // wen low = write
        for (int i = 0; i < `L2_BE_W; i++) begin
          if (req_i.be[i]) begin
            mem[req_i.row][8*i +: 8] <= req_i.wdata[8*i +: 8];
          end
        end
      end
      r_rdata_q <= mem[req_i.row];  // old word on a write
      r_id_q    <= req_i.id;
    end
  end

  // response valid for reads and writes alike
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      r_valid_q <= 1'b0;
    end else begin
      r_valid_q <= req_i.req;
    end
  end

  assign rsp_o.r_valid = r_valid_q;
  assign rsp_o.r_rdata = r_rdata_q;
  assign rsp_o.r_id    = r_id_q;

  a_write_be : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (req_i.req && !req_i.wen) |-> (req_i.be != '0)
  ) else $error("write to row %0d with empty byte enable", req_i.row);

endmodule

// File: source/l2_xbar.sv
/*
  Crossbar between initiators and banks: one decoder per initiator, one
  round-robin arbiter per bank, and the ID-based response router.
*/
`timescale 1ns/100ps
`include "l2_xbar_config.svh"

module l2_xbar
  import l2_xbar_pkg::*;
(
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  l2_req_t      [`L2_N_MASTERS-1:0]    req_i,
  output master_id_t                          gnt_o,
  output l2_rsp_t      [`L2_N_MASTERS-1:0]    rsp_o,
  output l2_bank_req_t [`L2_N_BANKS-1:0]      bank_req_o,
  input  l2_bank_rsp_t [`L2_N_BANKS-1:0]      bank_rsp_i
);

  bank_sel_t  [`L2_N_MASTERS-1:0] dec_sel;   // per initiator, over banks
  row_t       [`L2_N_MASTERS-1:0] dec_row;
  master_id_t [`L2_N_BANKS-1:0]   sel_col;   // per bank, over initiators
  master_id_t [`L2_N_BANKS-1:0]   bank_gnt;

  for (genvar m = 0; m < `L2_N_MASTERS; m++) begin : g_dec
    l2_addr_decoder i_dec (
      .req_i      ( req_i[m]   ),
      .bank_sel_o ( dec_sel[m] ),
      .row_o      ( dec_row[m] )
    );
  end

  // transpose decoder rows into arbiter columns
  always_comb begin : transpose
    for (int b = 0; b < `L2_N_BANKS; b++) begin
      for (int m = 0; m < `L2_N_MASTERS; m++) begin
        sel_col[b][m] = dec_sel[m][b];
      end
    end
  end

  for (genvar b = 0; b < `L2_N_BANKS; b++) begin : g_arb
    l2_bank_arbiter i_arb (
      .clk_i      ( clk_i         ),
      .rst_ni     ( rst_ni        ),
      .req_i      ( req_i         ),
      .sel_i      ( sel_col[b]    ),
      .row_i      ( dec_row       ),
      .gnt_o      ( bank_gnt[b]   ),
      .bank_req_o ( bank_req_o[b] )
    );
  end

  // each initiator targets one bank, so at most one of these bits is set
  always_comb begin : gnt_merge
    gnt_o = '0;
    for (int b = 0; b < `L2_N_BANKS; b++) begin
      gnt_o = gnt_o | bank_gnt[b];
    end
  end

  l2_resp_router i_router (
    .bank_rsp_i ( bank_rsp_i ),
    .rsp_o      ( rsp_o      )
  );

  // fixed one-cycle latency end to end
  for (genvar m = 0; m < `L2_N_MASTERS; m++) begin : g_chk
    a_rsp_latency : assert property (
      @(posedge clk_i) disable iff (!rst_ni)
      gnt_o[m] |=> rsp_o[m].r_valid
    ) else $error("initiator %0d granted without response next cycle", m);

    a_no_spurious : assert property (
      @(posedge clk_i) disable iff (!rst_ni)
      !gnt_o[m] |=> !rsp_o[m].r_valid
    ) else $error("initiator %0d got response without grant", m);
  end

endmodule

// File: source/l2_xbar_pkg.sv
/*
  Types for the L2 interconnect: vector widths and the request/response
  structs that travel between initiators, crossbar and banks.
*/
`include "l2_xbar_config.svh"

package l2_xbar_pkg;

  typedef logic [`L2_ADDR_W-1:0]    addr_t;       // byte address
  typedef logic [`L2_DATA_W-1:0]    data_t;
  typedef logic [`L2_BE_W-1:0]      be_t;
  typedef logic [`L2_ROW_W-1:0]     row_t;        // word index inside a bank
  typedef logic [`L2_N_BANKS-1:0]   bank_sel_t;   // one-hot over banks
  typedef logic [`L2_N_MASTERS-1:0] master_id_t;  // one-hot over initiators

  // initiator request, wen high means read
  typedef struct packed {
    logic  req;
    logic  wen;
    addr_t add;
    data_t wdata;
    be_t   be;
  } l2_req_t;

  typedef struct packed {
    logic  r_valid;
    data_t r_rdata;
  } l2_rsp_t;

  // request as seen by one bank, id names the winning initiator
  typedef struct packed {
    logic       req;
    logic       wen;
    row_t       row;
    data_t      wdata;
    be_t        be;
    master_id_t id;
  } l2_bank_req_t;

  typedef struct packed {
    logic       r_valid;
    data_t      r_rdata;
    master_id_t r_id;
  } l2_bank_rsp_t;

  // round-robin pointer, highest priority position
  typedef enum logic [$clog2(`L2_N_MASTERS)-1:0] {
    ARB_M0,
    ARB_M1,
    ARB_M2,
    ARB_M3
  } arb_state_e;

endpackage

// File: src.f
+incdir+include
source/l2_xbar_pkg.sv
source/l2_addr_decoder.sv
source/l2_bank_arbiter.sv
source/l2_resp_router.sv
source/l2_xbar.sv
source/l2_sram_bank.sv
source/l2_interconnect.sv
tests/tb_l2_interconnect.sv

// File: tests/tb_l2_interconnect.sv
/*
  Testbench for the L2 interconnect. Applies a table of directed requests,
  then random traffic checked against a reference memory model.
*/
`timescale 1ns/100ps
`include "l2_xbar_config.svh"

module tb_l2_interconnect
  import l2_xbar_pkg::*;
();

  localparam int N_ROWS   = 26;
  localparam int N_WORDS  = 2 ** (`L2_ADDR_W - 2);
  localparam int N_RANDOM = 200;

  // one initiator's share of a table row
  typedef struct packed {
    logic  en;
    logic  wen;     // high = read
    addr_t add;
    data_t wdata;
    be_t   be;
    logic  chk;     // compare read data
    data_t exp;
  } op_t;

  logic                         clk;
  logic                         rst_n;
  l2_req_t [`L2_N_MASTERS-1:0]  req;
  master_id_t                   gnt;
  l2_rsp_t [`L2_N_MASTERS-1:0]  rsp;

  op_t   tbl [N_ROWS][`L2_N_MASTERS];
  string row_names [N_ROWS];
  op_t   cur_ops [`L2_N_MASTERS];
  data_t ref_mem [N_WORDS];
  logic  ref_vld [N_WORDS];

  l2_interconnect uut (
    .clk_i  ( clk   ),
    .rst_ni ( rst_n ),
    .req_i  ( req   ),
    .gnt_o  ( gnt   ),
    .rsp_o  ( rsp   )
  );

  always #5 clk = ~clk;

  task automatic abort_run(input string why);
    $display("TESTBENCH FAILED");
    $fatal(1, "%s", why);
  endtask

  task automatic check_equal(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("ERROR %s: expected %h, actual %h", what, exp, act);
      abort_run("value mismatch");
    end
  endtask

  // a write updates only the enabled bytes
  function automatic data_t merge_bytes(data_t old_w, data_t new_w, be_t be);
    data_t res;
    res = old_w;
    for (int i = 0; i < `L2_BE_W; i++) begin
      if (be[i]) begin
        res[8*i +: 8] = new_w[8*i +: 8];
      end
    end
    return res;
  endfunction

  // banks addressed by the given initiators, byte offset is 2 bits
  function automatic int banks_in_use(master_id_t active);
    bank_sel_t busy;
    busy = '0;
    for (int m = 0; m < `L2_N_MASTERS; m++) begin
      if (active[m]) begin
        busy[(cur_ops[m].add >> 2) % `L2_N_BANKS] = 1'b1;
      end
    end
    return $countones(busy);
  endfunction

  task automatic set_op(input int r, input int m, input logic wen, input addr_t add,
                        input data_t wdata, input be_t be, input data_t exp);
    tbl[r][m] = '{en: 1'b1, wen: wen, add: add, wdata: wdata, be: be, chk: wen, exp: exp};
  endtask

  task automatic load_table();
    for (int r = 0; r < N_ROWS; r++) begin
      for (int m = 0; m < `L2_N_MASTERS; m++) begin
        tbl[r][m] = '0;
      end
    end
    // same row, bank field walks 0..7
    for (int b = 0; b < `L2_N_BANKS; b++) begin
      row_names[b]     = $sformatf("bank_wr_%0d", b);
      row_names[b + 8] = $sformatf("bank_rd_%0d", b);
      set_op(b, 0, 1'b0, {8'h05, b[2:0], 2'b00}, data_t'(32'h1000_0001 * (b + 1)), 4'hF, '0);
      set_op(b + 8, 1, 1'b1, {8'h05, b[2:0], 2'b00}, '0, 4'hF,
             data_t'(32'h1000_0001 * (b + 1)));
    end
    row_names[16] = "part_full_wr";
    set_op(16, 2, 1'b0, 13'h024C, 32'h1122_3344, 4'hF, '0);
    row_names[17] = "part_be_0101";
    set_op(17, 2, 1'b0, 13'h024C, 32'hAABB_CCDD, 4'b0101, '0);
    row_names[18] = "part_be_1000";
    set_op(18, 3, 1'b0, 13'h024C, 32'h9988_7766, 4'b1000, '0);
    row_names[19] = "part_merge_rd";
    set_op(19, 0, 1'b1, 13'h024C, '0, 4'hF, 32'h99BB_33DD);
    // all four on bank 6
    row_names[20] = "same_bank_wr";
    set_op(20, 0, 1'b0, 13'h0618, 32'hDEAD_0000, 4'hF, '0);
    set_op(20, 1, 1'b0, 13'h0638, 32'hDEAD_0101, 4'hF, '0);
    set_op(20, 2, 1'b0, 13'h0658, 32'hDEAD_0202, 4'hF, '0);
    set_op(20, 3, 1'b0, 13'h0678, 32'hDEAD_0303, 4'hF, '0);
    row_names[21] = "same_bank_rd";  // crossed, so routing by ID matters
    set_op(21, 0, 1'b1, 13'h0678, '0, 4'hF, 32'hDEAD_0303);
    set_op(21, 1, 1'b1, 13'h0658, '0, 4'hF, 32'hDEAD_0202);
    set_op(21, 2, 1'b1, 13'h0638, '0, 4'hF, 32'hDEAD_0101);
    set_op(21, 3, 1'b1, 13'h0618, '0, 4'hF, 32'hDEAD_0000);
    // banks 0..3, all granted in one cycle
    row_names[22] = "diff_bank_wr";
    set_op(22, 0, 1'b0, 13'h0800, 32'h0BAD_F00D, 4'hF, '0);
    set_op(22, 1, 1'b0, 13'h0824, 32'hCAFE_0001, 4'hF, '0);
    set_op(22, 2, 1'b0, 13'h0848, 32'hCAFE_0002, 4'hF, '0);
    set_op(22, 3, 1'b0, 13'h086C, 32'hCAFE_0003, 4'hF, '0);
    row_names[23] = "diff_bank_rd";
    set_op(23, 0, 1'b1, 13'h0800, '0, 4'hF, 32'h0BAD_F00D);
    set_op(23, 1, 1'b1, 13'h0824, '0, 4'hF, 32'hCAFE_0001);
    set_op(23, 2, 1'b1, 13'h0848, '0, 4'hF, 32'hCAFE_0002);
    set_op(23, 3, 1'b1, 13'h086C, '0, 4'hF, 32'hCAFE_0003);
    row_names[24] = "top_row_wr";
    set_op(24, 1, 1'b0, 13'h1FFC, 32'h5A5A_A5A5, 4'hF, '0);
    row_names[25] = "top_row_rd";
    set_op(25, 2, 1'b1, 13'h1FFC, '0, 4'hF, 32'h5A5A_A5A5);
  endtask

  task automatic drive_reqs(input master_id_t active);
    for (int m = 0; m < `L2_N_MASTERS; m++) begin
      req[m] = '0;
      if (active[m]) begin
        req[m].req   = 1'b1;
        req[m].wen   = cur_ops[m].wen;
        req[m].add   = cur_ops[m].add;
        req[m].wdata = cur_ops[m].wdata;
        req[m].be    = cur_ops[m].be;
      end
    end
  endtask

  task automatic update_ref(input op_t op);
    int unsigned w;
    w = int'(op.add >> 2);
    if (ref_vld[w] || op.be == '1) begin
      ref_mem[w] = merge_bytes(ref_mem[w], op.wdata, op.be);
      ref_vld[w] = 1'b1;
    end
  endtask

  // called 1 ns after a rising edge, returns at the same point
  task automatic run_row(input string name);
    master_id_t  pending;
    master_id_t  await_rsp;
    master_id_t  gnt_now;
    int unsigned n_cyc;
    pending = '0;
    for (int m = 0; m < `L2_N_MASTERS; m++) begin
      pending[m] = cur_ops[m].en;
    end
    await_rsp = '0;
    n_cyc     = 0;
    drive_reqs(pending);
    while (pending != '0 || await_rsp != '0) begin
      @(negedge clk);
      for (int m = 0; m < `L2_N_MASTERS; m++) begin
        if (await_rsp[m]) begin  // granted last cycle
          check_equal($sformatf("%s m%0d r_valid", name, m), 32'd1, 32'(rsp[m].r_valid));
          if (cur_ops[m].chk) begin
            check_equal($sformatf("%s m%0d r_rdata", name, m), cur_ops[m].exp,
                        rsp[m].r_rdata);
          end
        end else begin
          check_equal($sformatf("%s m%0d idle r_valid", name, m), 32'd0,
                      32'(rsp[m].r_valid));
        end
      end
      gnt_now = gnt;
      check_equal({name, " grant to idle initiator"}, 32'd0, 32'(gnt_now & ~pending));
      // every bank with a requester grants exactly one
      check_equal({name, " grant count"}, 32'(banks_in_use(pending)),
                  32'($countones(gnt_now)));
      for (int m = 0; m < `L2_N_MASTERS; m++) begin
        if (gnt_now[m] && !cur_ops[m].wen) begin
          update_ref(cur_ops[m]);
        end
      end
      await_rsp = gnt_now & pending;
      pending   = pending & ~gnt_now;
      n_cyc++;
      if (pending != '0 && n_cyc >= `L2_N_MASTERS) begin
        $display("timeout in %s: initiators %b not granted within %0d cycles",
                 name, pending, n_cyc);
        abort_run("grant timeout");
      end
      @(posedge clk);
      #1;
      drive_reqs(pending);
    end
  endtask

  task automatic check_idle(input string name, input int n_cyc);
    for (int i = 0; i < n_cyc; i++) begin
      @(negedge clk);
      check_equal({name, " gnt"}, 32'd0, 32'(gnt));
      for (int m = 0; m < `L2_N_MASTERS; m++) begin
        check_equal($sformatf("%s m%0d r_valid", name, m), 32'd0, 32'(rsp[m].r_valid));
      end
    end
    @(posedge clk);
    #1;
  endtask

  // odd stride over 64 words, so the picks of one batch never collide
  task automatic build_random_batch(input int max_new, output int n_new);
    master_id_t  mask;
    int unsigned start;
    int unsigned step;
    int unsigned word;
    int          k;
    mask = master_id_t'($urandom);
    if (mask == '0) begin
      mask = master_id_t'(1 << ($urandom % `L2_N_MASTERS));
    end
    start = $urandom % 64;
    step  = 2 * ($urandom % 8) + 1;
    k     = 0;
    n_new = 0;
    for (int m = 0; m < `L2_N_MASTERS; m++) begin
      cur_ops[m] = '0;
      if (mask[m] && n_new < max_new) begin
        word              = (start + k * step) % 64;
        k++;
        cur_ops[m].en     = 1'b1;
        cur_ops[m].wen    = 1'($urandom % 2);
        cur_ops[m].add    = addr_t'(word << 2);
        cur_ops[m].wdata  = $urandom;
        cur_ops[m].be     = '1;
        cur_ops[m].chk    = cur_ops[m].wen && ref_vld[word];
        cur_ops[m].exp    = ref_mem[word];
        n_new++;
      end
    end
  endtask

  initial begin : main
    int n_req;
    int n_new;
    clk   = 1'b0;
    rst_n = 1'b0;
    req   = '0;
    void'($urandom(32'he2b2));
    for (int w = 0; w < N_WORDS; w++) begin
      ref_mem[w] = '0;
      ref_vld[w] = 1'b0;
    end
    load_table();
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    check_idle("idle_after_reset", 4);
    for (int r = 0; r < N_ROWS; r++) begin
      for (int m = 0; m < `L2_N_MASTERS; m++) begin
        cur_ops[m] = tbl[r][m];
      end
      run_row(row_names[r]);
    end
    n_req = 0;
    while (n_req < N_RANDOM) begin
      build_random_batch(N_RANDOM - n_req, n_new);
      run_row("random");
      n_req += n_new;
    end
    check_idle("idle_at_end", 2);
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule
